/* common/packet_pkg.sv */
`default_nettype none

package packet_pkg;

    // ============================================================
    // Stream geometry
    // ============================================================

    // Wide input beat and narrow output word in bytes
    localparam int DATA_IN_BYTE_WID  = 8;
    localparam int DATA_OUT_BYTE_WID = 2;

    localparam int IN_DATA_WID  = DATA_IN_BYTE_WID * 8;
    localparam int OUT_DATA_WID = DATA_OUT_BYTE_WID * 8;

    // Narrow words carried by one wide beat
    localparam int WORDS_PER_BEAT = DATA_IN_BYTE_WID / DATA_OUT_BYTE_WID;
    localparam int WORD_IDX_WID   = $clog2(WORDS_PER_BEAT);

    // Empty byte counts at the top of a last beat / last word
    localparam int IN_MTY_WID  = $clog2(DATA_IN_BYTE_WID);
    localparam int OUT_MTY_WID = $clog2(DATA_OUT_BYTE_WID);

    // ============================================================
    // Outputs, metadata and events
    // ============================================================

    localparam int NUM_OUTPUTS = 3;
    localparam int CTXT_WID    = $clog2(NUM_OUTPUTS);

    // Per-packet metadata that is valid on the last beat only
    localparam int META_WID = 16;

    // Packet byte count reported at end of packet
    localparam int SIZE_WID = 16;

endpackage : packet_pkg

`default_nettype wire

/* packet_disaggregate/packet_width_converter.sv */
`default_nettype none

module packet_width_converter (
    input  logic                              clk,
    input  logic                              rst,
    // Wide input beats
    input  logic                              in_vld,
    output logic                              in_rdy,
    input  logic [packet_pkg::IN_DATA_WID-1:0] in_data,
    input  logic                              in_eop,
    input  logic [packet_pkg::IN_MTY_WID-1:0]  in_mty,
    input  logic [packet_pkg::META_WID-1:0]    in_meta,
    // Narrow words towards the demux
    output logic                               cv_vld,
    input  logic                               cv_rdy,
    output logic [packet_pkg::OUT_DATA_WID-1:0] cv_data,
    output logic                               cv_eop,
    output logic [packet_pkg::OUT_MTY_WID-1:0]  cv_mty,
    output logic [packet_pkg::META_WID-1:0]     cv_meta,
    output logic                               cv_sop
);
    import packet_pkg::*;

    // Holding register for one beat
    logic                    beat_vld;
    logic [IN_DATA_WID-1:0]  beat_data;
    logic                    beat_eop;
    logic [META_WID-1:0]     beat_meta;
    logic                    beat_sop;
    logic [WORD_IDX_WID-1:0] last_idx;
    logic [OUT_MTY_WID-1:0]  last_mty;
    logic [WORD_IDX_WID-1:0] word_idx;

    // Next accepted beat opens a packet
    logic in_sop;
    logic rdy_en;

    logic [IN_MTY_WID-1:0]   in_mty_eff;
    logic [IN_MTY_WID-1:0]   in_last_byte;
    logic [WORD_IDX_WID-1:0] in_last_idx;
    logic [OUT_MTY_WID-1:0]  in_last_mty;

    logic last_word;
    logic word_xfer;
    logic beat_done;
    logic in_xfer;

    // ============================================================
    // Beat geometry at acceptance
    // ============================================================

    // Only the last beat of a packet may be short
    assign in_mty_eff   = in_eop ? in_mty : '0;
    assign in_last_byte = IN_MTY_WID'(DATA_IN_BYTE_WID - 1) - in_mty_eff;
    assign in_last_idx  = WORD_IDX_WID'(in_last_byte / DATA_OUT_BYTE_WID);
    assign in_last_mty  = OUT_MTY_WID'(DATA_OUT_BYTE_WID - 1 -
                                       (in_last_byte % DATA_OUT_BYTE_WID));

    // ============================================================
    // Handshake
    // ============================================================

    assign last_word = (word_idx == last_idx);
    assign word_xfer = cv_vld && cv_rdy;
    assign beat_done = word_xfer && last_word;

    // Refill in the cycle the final word leaves
    assign in_rdy  = rdy_en && (!beat_vld || beat_done);
    assign in_xfer = in_vld && in_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            rdy_en   <= 1'b0;
            beat_vld <= 1'b0;
            word_idx <= '0;
            in_sop   <= 1'b1;
        end else begin
            rdy_en <= 1'b1;
            if (in_xfer) begin
                beat_vld <= 1'b1;
                word_idx <= '0;
                in_sop   <= in_eop;
            end else if (beat_done) begin
                beat_vld <= 1'b0;
            end else if (word_xfer) begin
                word_idx <= word_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer) begin
            beat_data <= in_data;
            beat_eop  <= in_eop;
            beat_meta <= in_meta;
            beat_sop  <= in_sop;
            last_idx  <= in_last_idx;
            last_mty  <= in_last_mty;
        end
    end

    // ============================================================
    // Word output with byte 0 first
    // ============================================================

    assign cv_vld  = beat_vld;
    assign cv_data = beat_data[word_idx*OUT_DATA_WID +: OUT_DATA_WID];
    assign cv_eop  = beat_vld && beat_eop && last_word;
    assign cv_mty  = cv_eop ? last_mty : '0;
    assign cv_meta = cv_eop ? beat_meta : '0;
    assign cv_sop  = beat_vld && beat_sop && (word_idx == '0);

    // A finished packet is followed by the first word of the next one
    eop_then_sop : assert property (@(posedge clk) disable iff (rst)
        cv_vld && cv_rdy && cv_eop |=> !cv_vld || cv_sop);

    // A stalled word must not change under the consumer
    stall_holds_word : assert property (@(posedge clk) disable iff (rst)
        cv_vld && !cv_rdy |=> cv_vld && $stable(cv_data) && $stable(cv_eop));

endmodule : packet_width_converter

`default_nettype wire

/* packet_disaggregate/packet_ctxt_demux.sv */
`default_nettype none

module packet_ctxt_demux (
    input  logic                                clk,
    input  logic                                rst,
    // Narrow words from the converter
    input  logic                                cv_vld,
    output logic                                cv_rdy,
    input  logic [packet_pkg::OUT_DATA_WID-1:0] cv_data,
    input  logic                                cv_eop,
    input  logic [packet_pkg::OUT_MTY_WID-1:0]  cv_mty,
    input  logic [packet_pkg::META_WID-1:0]     cv_meta,
    input  logic                                cv_sop,
    // Output select as a level
    input  logic [packet_pkg::CTXT_WID-1:0]     ctxt_sel,
    // Per-output streams
    output logic [packet_pkg::NUM_OUTPUTS-1:0]  out_vld,
    input  logic [packet_pkg::NUM_OUTPUTS-1:0]  out_rdy,
    output logic [packet_pkg::NUM_OUTPUTS-1:0][packet_pkg::OUT_DATA_WID-1:0] out_data,
    output logic [packet_pkg::NUM_OUTPUTS-1:0]  out_eop,
    output logic [packet_pkg::NUM_OUTPUTS-1:0][packet_pkg::OUT_MTY_WID-1:0]  out_mty,
    output logic [packet_pkg::NUM_OUTPUTS-1:0][packet_pkg::META_WID-1:0]     out_meta,
    // Context report
    output logic                                ctxt_out_valid,
    output logic [packet_pkg::CTXT_WID-1:0]     ctxt_out
);
    import packet_pkg::*;

    logic [CTXT_WID-1:0]    ctxt_lat;
    logic [CTXT_WID-1:0]    cur_ctxt;
    logic [NUM_OUTPUTS-1:0] sel_hit;
    logic                   sop_xfer;

    // ============================================================
    // Context selection
    // ============================================================

    // First word steers from the live select, the rest from the latch
    assign cur_ctxt = cv_sop ? ctxt_sel : ctxt_lat;
    assign sop_xfer = cv_vld && cv_sop && cv_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            ctxt_lat <= '0;
        end else if (sop_xfer) begin
            ctxt_lat <= ctxt_sel;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_OUTPUTS; i++) begin
            sel_hit[i] = (cur_ctxt == CTXT_WID'(i));
        end
    end

    // ============================================================
    // Routing
    // ============================================================

    // Payload fans out to all; valid and eop only on the chosen one
    assign out_vld  = sel_hit & {NUM_OUTPUTS{cv_vld}};
    assign out_eop  = sel_hit & {NUM_OUTPUTS{cv_eop}};
    assign out_data = {NUM_OUTPUTS{cv_data}};
    assign out_mty  = {NUM_OUTPUTS{cv_mty}};
    assign out_meta = {NUM_OUTPUTS{cv_meta}};

    assign cv_rdy = |(sel_hit & out_rdy);

    assign ctxt_out_valid = sop_xfer;
    assign ctxt_out       = cur_ctxt;

    // An unmapped select would stall the stream for good
    sel_in_range : assert property (@(posedge clk) disable iff (rst)
        cv_vld && cv_sop |-> ctxt_sel < CTXT_WID'(NUM_OUTPUTS));

endmodule : packet_ctxt_demux

`default_nettype wire

/* packet_disaggregate/packet_event_tap.sv */
`default_nettype none

module packet_event_tap (
    input  logic                               clk,
    input  logic                               rst,
    // Word transfers seen on one output
    input  logic                               word_xfer,
    input  logic                               word_eop,
    input  logic [packet_pkg::OUT_MTY_WID-1:0] word_mty,
    // Packet length event
    output logic                               event_out_vld,
    output logic [packet_pkg::SIZE_WID-1:0]    event_out_size
);
    import packet_pkg::*;

    logic [SIZE_WID-1:0] byte_cnt;
    logic [SIZE_WID-1:0] word_bytes;
    logic [SIZE_WID-1:0] pkt_total;

    // ============================================================
    // Byte counting
    // ============================================================

    // Empty bytes only ever sit in the last word
    assign word_bytes = SIZE_WID'(DATA_OUT_BYTE_WID) - SIZE_WID'(word_mty);
    assign pkt_total  = byte_cnt + word_bytes;

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt <= '0;
        end else if (word_xfer) begin
            if (word_eop) begin
                byte_cnt <= '0;
            end else begin
                byte_cnt <= pkt_total;
            end
        end
    end

    // ============================================================
    // Event output
    // ============================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            event_out_vld <= 1'b0;
        end else begin
            event_out_vld <= word_xfer && word_eop;
        end
    end

    // Total of the packet just finished
    always_ff @(posedge clk) begin
        if (word_xfer && word_eop) begin
            event_out_size <= pkt_total;
        end
    end

endmodule : packet_event_tap

`default_nettype wire

/* packet_disaggregate/packet_disaggregate.sv */
`default_nettype none

module packet_disaggregate (
    input  logic                                clk,
    input  logic                                rst,
    // Wide input stream
    input  logic                                in_vld,
    output logic                                in_rdy,
    input  logic [packet_pkg::IN_DATA_WID-1:0]  in_data,
    input  logic                                in_eop,
    input  logic [packet_pkg::IN_MTY_WID-1:0]   in_mty,
    input  logic [packet_pkg::META_WID-1:0]     in_meta,
    // Output select
    input  logic [packet_pkg::CTXT_WID-1:0]     ctxt_sel,
    // Narrow output streams
    output logic [packet_pkg::NUM_OUTPUTS-1:0]  out_vld,
    input  logic [packet_pkg::NUM_OUTPUTS-1:0]  out_rdy,
    output logic [packet_pkg::NUM_OUTPUTS-1:0][packet_pkg::OUT_DATA_WID-1:0] out_data,
    output logic [packet_pkg::NUM_OUTPUTS-1:0]  out_eop,
    output logic [packet_pkg::NUM_OUTPUTS-1:0][packet_pkg::OUT_MTY_WID-1:0]  out_mty,
    output logic [packet_pkg::NUM_OUTPUTS-1:0][packet_pkg::META_WID-1:0]     out_meta,
    // Context report
    output logic                                ctxt_out_valid,
    output logic [packet_pkg::CTXT_WID-1:0]     ctxt_out,
    // Per-output length events
    output logic [packet_pkg::NUM_OUTPUTS-1:0]  event_out_vld,
    output logic [packet_pkg::NUM_OUTPUTS-1:0][packet_pkg::SIZE_WID-1:0] event_out_size
);
    import packet_pkg::*;

    // Converter to demux
    logic                    cv_vld;
    logic                    cv_rdy;
    logic [OUT_DATA_WID-1:0] cv_data;
    logic                    cv_eop;
    logic [OUT_MTY_WID-1:0]  cv_mty;
    logic [META_WID-1:0]     cv_meta;
    logic                    cv_sop;

    packet_width_converter u_conv (
        .clk, .rst,
        .in_vld, .in_rdy, .in_data, .in_eop, .in_mty, .in_meta,
        .cv_vld, .cv_rdy, .cv_data, .cv_eop, .cv_mty, .cv_meta, .cv_sop
    );

    packet_ctxt_demux u_demux (
        .clk, .rst,
        .cv_vld, .cv_rdy, .cv_data, .cv_eop, .cv_mty, .cv_meta, .cv_sop,
        .ctxt_sel,
        .out_vld, .out_rdy, .out_data, .out_eop, .out_mty, .out_meta,
        .ctxt_out_valid, .ctxt_out
    );

    // One length counter per output
    for (genvar g = 0; g < NUM_OUTPUTS; g++) begin : g_tap
        packet_event_tap u_tap (
            .clk, .rst,
            .word_xfer      (out_vld[g] & out_rdy[g]),
            .word_eop       (out_eop[g]),
            .word_mty       (out_mty[g]),
            .event_out_vld  (event_out_vld[g]),
            .event_out_size (event_out_size[g])
        );
    end : g_tap

endmodule : packet_disaggregate

`default_nettype wire

/* tb/packet_disaggregate_tb.sv */
`default_nettype none

module packet_disaggregate_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import packet_pkg::*;

    localparam int NUM_RAND = 200;
    localparam int NUM_PKTS = NUM_RAND + 5;
    localparam logic [31:0] LFSR_POLY = 32'hB4BCD35C;

    typedef struct packed {
        logic [OUT_DATA_WID-1:0] data;
        logic                    eop;
        logic [OUT_MTY_WID-1:0]  mty;
        logic [META_WID-1:0]     meta;
    } word_t;

    logic                                     clk, rst, in_vld, in_rdy, in_eop;
    logic [IN_DATA_WID-1:0]                   in_data;
    logic [IN_MTY_WID-1:0]                    in_mty;
    logic [META_WID-1:0]                      in_meta;
    logic [CTXT_WID-1:0]                      ctxt_sel, ctxt_out;
    logic                                     ctxt_out_valid;
    logic [NUM_OUTPUTS-1:0]                   out_vld, out_rdy, out_eop, event_out_vld;
    logic [NUM_OUTPUTS-1:0][OUT_DATA_WID-1:0] out_data;
    logic [NUM_OUTPUTS-1:0][OUT_MTY_WID-1:0]  out_mty;
    logic [NUM_OUTPUTS-1:0][META_WID-1:0]     out_meta;
    logic [NUM_OUTPUTS-1:0][SIZE_WID-1:0]     event_out_size;

    logic [31:0]         drv_lfsr = 32'h943;
    logic [31:0]         stall_lfsr = 32'h943;
    logic                stalls_on = 1'b0;
    word_t               exp_words [NUM_OUTPUTS][$];
    logic [SIZE_WID-1:0] exp_sizes [NUM_OUTPUTS][$];
    logic [CTXT_WID-1:0] exp_ctxt [$];

    packet_disaggregate dut0 (.*);

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // ============================================================
    // Random source and reference model
    // ============================================================

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], drv_lfsr[0]};
            drv_lfsr = lfsr_step(drv_lfsr);
        end
        return int'(v);
    endfunction

    // Byte 0 goes low in each word and a short last word leaves its top byte empty
    function automatic void ref_words(input logic [7:0] bytes [40], input int len,
                                      input logic [CTXT_WID-1:0] sel,
                                      input logic [META_WID-1:0] meta);
        word_t w;
        int    nwords;
        nwords = (len + 1) / 2;
        for (int k = 0; k < nwords; k++) begin
            w.data = {bytes[2*k+1], bytes[2*k]};
            w.eop  = (k == nwords - 1);
            w.mty  = w.eop ? OUT_MTY_WID'(2 * nwords - len) : '0;
            w.meta = w.eop ? meta : '0;
            exp_words[sel].push_back(w);
        end
    endfunction

    function automatic int pending(input bit events_only);
        int n;
        n = events_only ? 0 : exp_ctxt.size();
        for (int o = 0; o < NUM_OUTPUTS; o++) begin
            n += exp_sizes[o].size() + (events_only ? 0 : exp_words[o].size());
        end
        return n;
    endfunction

    // ============================================================
    // Checks
    // ============================================================

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_word(input int o, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_on_failure($sformatf({"Error at %0t: output %0d word %h/%b/%b/%h,",
                " expected %h/%b/%b/%h"}, $time, o, got.data, got.eop, got.mty,
                got.meta, exp.data, exp.eop, exp.mty, exp.meta));
        end
    endtask

    task automatic check_ctxt(input logic [CTXT_WID-1:0] got, input logic [CTXT_WID-1:0] exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("Error at %0t: ctxt_out %0d, expected %0d",
                $time, got, exp));
        end
    endtask

    task automatic check_event(input int o, input logic [SIZE_WID-1:0] got,
                               input logic [SIZE_WID-1:0] exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("Error at %0t: output %0d event size %0d, expected %0d",
                $time, o, got, exp));
        end
    endtask

    // Sampled mid-cycle so a transfer seen here completes at the next rising edge
    initial begin : compare_outputs
        word_t got;
        int    cycle;
        int    first_acc;
        int    first_word;
        cycle = 0;
        first_acc = -1;
        first_word = -1;
        forever begin
            @(negedge clk);
            cycle++;
            if (!rst) begin
                if (first_acc < 0 && (|out_vld || ctxt_out_valid || |event_out_vld)) begin
                    stop_on_failure("Output activity was seen before the first input beat");
                end
                if (first_acc < 0 && in_vld && in_rdy) begin
                    first_acc = cycle;
                end
                for (int o = 0; o < NUM_OUTPUTS; o++) begin
                    if (out_vld[o] && out_rdy[o]) begin
                        if (first_word < 0) begin
                            first_word = cycle;
                            if (first_word != first_acc + 1) begin
                                stop_on_failure(
                                    "First word did not follow the first beat by one cycle");
                            end
                        end
                        got = {out_data[o], out_eop[o], out_mty[o], out_meta[o]};
                        if (exp_words[o].size() == 0) begin
                            stop_on_failure($sformatf("Unexpected word on output %0d", o));
                        end else begin
                            check_word(o, got, exp_words[o].pop_front());
                        end
                    end
                    if (event_out_vld[o]) begin
                        if (exp_sizes[o].size() == 0) begin
                            stop_on_failure($sformatf("Unexpected event on output %0d", o));
                        end else begin
                            check_event(o, event_out_size[o], exp_sizes[o].pop_front());
                        end
                    end
                end
                if (ctxt_out_valid) begin
                    if (exp_ctxt.size() == 0) begin
                        stop_on_failure("Unexpected context report");
                    end else begin
                        check_ctxt(ctxt_out, exp_ctxt.pop_front());
                    end
                end
            end
        end
    end

    // ============================================================
    // Stimulus
    // ============================================================

    // Two bits per output each cycle and a stall when both are zero
    initial begin : drive_stalls
        logic b;
        out_rdy = '1;
        forever begin
            @(posedge clk);
            #10;
            for (int o = 0; o < NUM_OUTPUTS; o++) begin
                b = stall_lfsr[0];
                stall_lfsr = lfsr_step(stall_lfsr);
                out_rdy[o] = !stalls_on || b || stall_lfsr[0];
                stall_lfsr = lfsr_step(stall_lfsr);
            end
        end
    end

    task automatic send_packet(input int len);
        logic [7:0]          bytes [40];
        logic [META_WID-1:0] meta;
        logic [CTXT_WID-1:0] sel;
        int                  nbeats;
        sel = CTXT_WID'(take_bits(2) % NUM_OUTPUTS);
        for (int k = 0; k < 40; k++) begin
            bytes[k] = (k < len) ? 8'(take_bits(8)) : 8'h00;
        end
        meta = META_WID'(take_bits(META_WID));
        ref_words(bytes, len, sel, meta);
        exp_ctxt.push_back(sel);
        exp_sizes[sel].push_back(SIZE_WID'(len));
        nbeats = (len + 7) / 8;
        ctxt_sel = sel;
        for (int b = 0; b < nbeats; b++) begin
            for (int k = 0; k < 8; k++) begin
                in_data[k*8 +: 8] = bytes[b*8+k];
            end
            in_eop  = (b == nbeats - 1);
            in_mty  = in_eop ? IN_MTY_WID'(nbeats * 8 - len) : '0;
            in_meta = in_eop ? meta : '0;
            in_vld  = 1'b1;
            @(negedge clk);
            while (!in_rdy) @(negedge clk);
            @(posedge clk);
            #10;
            in_vld = 1'b0;
            if (b == 0) begin
                // Move the select away once the first word has gone out
                @(negedge clk);
                while (!ctxt_out_valid) @(negedge clk);
                @(posedge clk);
                #10;
                ctxt_sel = CTXT_WID'((int'(sel) + 1 + take_bits(1)) % NUM_OUTPUTS);
            end
        end
    endtask

    initial begin : watchdog
        repeat (NUM_PKTS * 60) @(posedge clk);
        stop_on_failure("The run timed out before all packets were checked");
    end

    initial begin : run_tests
        rst      = 1'b1;
        in_vld   = 1'b0;
        in_data  = '0;
        in_eop   = 1'b0;
        in_mty   = '0;
        in_meta  = '0;
        ctxt_sel = '0;
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;
        // Lengths around word and beat boundaries with no stalls
        send_packet(1);
        send_packet(7);
        send_packet(8);
        send_packet(9);
        send_packet(16);
        stalls_on = 1'b1;
        repeat (NUM_RAND) begin
            send_packet(1 + take_bits(6) % 40);
        end
        while (pending(1'b1) != 0) @(negedge clk);
        repeat (10) @(negedge clk);
        if (pending(1'b0) == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            stop_on_failure("Expected words or context reports were never seen");
        end
    end

endmodule : packet_disaggregate_tb

`default_nettype wire

/* project.f */
common/packet_pkg.sv
packet_disaggregate/packet_width_converter.sv
packet_disaggregate/packet_ctxt_demux.sv
packet_disaggregate/packet_event_tap.sv
packet_disaggregate/packet_disaggregate.sv
tb/packet_disaggregate_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module packet_disaggregate_tb \
    --Mdir obj_dir -o sim_tb

# Result is read from the log, not from the exit status
./obj_dir/sim_tb | tee sim.log

if grep -q "Testbench failed" sim.log || ! grep -q "Testbench passed" sim.log; then
    echo "Simulation result: FAIL"
    exit 1
fi
echo "Simulation result: PASS"
